// ==== hdl/data_obi_defs.svh ====
// Widths and fixed OBI field values; depth above 3 needs a wider outstanding counter
`ifndef DATA_OBI_DEFS_SVH
`define DATA_OBI_DEFS_SVH

// Address and data bus widths
`define DATA_ADDR_W 32
`define DATA_W 32

// Request and response checksum widths
`define ACHK_W 12
`define RCHK_W 5

// Depth of the in-order tracking FIFO
`define DATA_MAX_OUTSTANDING 2

// Fixed A-channel attributes that enter the checksum
// Machine mode data access
`define OBI_DATA_PROT 3'b111
`define OBI_DATA_MEMTYPE 2'b00
`define OBI_DATA_ATOP 6'b000000
`define OBI_DATA_DBG 1'b0

`endif

// ==== hdl/obi_pkg.sv ====
// Bus-side types only; atomics are not supported so no atop encoding is defined
package obi_pkg;

  ////////////////////////////////////////////////////////////
  // Transfer opcode
  ////////////////////////////////////////////////////////////

  // One bit, maps directly onto the OBI we signal
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } data_op_e;

  ////////////////////////////////////////////////////////////
  // Outstanding transfer tracking entry
  ////////////////////////////////////////////////////////////

  // Captured when the address phase is accepted
  // Read back when the matching response arrives
  typedef struct packed {
    logic integrity;
    logic gnterr;
    logic store;
  } trk_entry_t;

endpackage

// ==== hdl/integrity_pkg.sv ====
// Integrity-side types; source encoding is fixed at 2 bits for three error kinds
package integrity_pkg;

  // First error source captured by the alert unit
  // ALERT_NONE only while no alert is raised
  typedef enum logic [1:0] {
    ALERT_NONE      = 2'd0,
    ALERT_GNTPAR    = 2'd1,
    ALERT_RVALIDPAR = 2'd2,
    ALERT_RCHK      = 2'd3
  } alert_src_e;

  // Alert unit state
  typedef enum logic {
    ALERT_IDLE   = 1'b0,
    ALERT_RAISED = 1'b1
  } alert_state_e;

endpackage

// ==== hdl/rchk_check.sv ====
// Checks one response per cycle; caller gates enable_i with rvalid and integrity enable
`include "data_obi_defs.svh"

module rchk_check (
  input  logic [`DATA_W-1:0] rdata_i,
  input  logic               err_i,
  input  logic [`RCHK_W-1:0] rchk_i,
  // Bit 0 enables data byte bits, bit 1 enables the err bit
  input  logic [1:0]         enable_i,
  output logic               err_o
);

  localparam int NBYTES = `DATA_W / 8;

  logic [`RCHK_W-1:0] rchk_exp;
  logic               data_mismatch;
  logic               err_mismatch;

  // Expected checksum
  // One even parity bit per read data byte, top bit covers err
  always_comb begin
    rchk_exp = '0;
    for (int i = 0; i < NBYTES; i++) begin
      rchk_exp[i] = ^rdata_i[8*i +: 8];
    end
    rchk_exp[`RCHK_W-1] = ^err_i;
  end

  assign data_mismatch = (rchk_i[NBYTES-1:0] != rchk_exp[NBYTES-1:0]);
  assign err_mismatch  = (rchk_i[`RCHK_W-1] != rchk_exp[`RCHK_W-1]);

  // Only enabled groups may flag
  assign err_o = (enable_i[0] && data_mismatch) || (enable_i[1] && err_mismatch);

endmodule

// ==== hdl/data_obi_adapter.sv ====
// No outstanding limit is enforced; bus must keep in-flight transfers within FIFO depth
`include "data_obi_defs.svh"

module data_obi_adapter (
  input  logic                      clk,
  input  logic                      rst_n,
  // Core request channel
  input  logic                      trans_valid_i,
  output logic                      trans_ready_o,
  input  obi_pkg::data_op_e         trans_op_i,
  input  logic [`DATA_ADDR_W-1:0]   trans_addr_i,
  input  logic [`DATA_W/8-1:0]      trans_be_i,
  input  logic [`DATA_W-1:0]        trans_wdata_i,
  input  logic                      trans_integrity_i,
  // Core response channel, core is always ready
  output logic                      resp_valid_o,
  output logic [`DATA_W-1:0]        resp_rdata_o,
  output logic                      resp_err_o,
  output logic                      resp_integrity_o,
  output logic                      resp_parity_err_o,
  output logic                      resp_rchk_err_o,
  // OBI A channel
  output logic                      obi_req_o,
  output logic                      obi_reqpar_o,
  input  logic                      obi_gnt_i,
  input  logic                      obi_gntpar_i,
  output logic [`DATA_ADDR_W-1:0]   obi_addr_o,
  output logic                      obi_we_o,
  output logic [`DATA_W/8-1:0]      obi_be_o,
  output logic [`DATA_W-1:0]        obi_wdata_o,
  output logic [`ACHK_W-1:0]        obi_achk_o,
  // OBI R channel
  input  logic                      obi_rvalid_i,
  input  logic                      obi_rvalidpar_i,
  input  logic [`DATA_W-1:0]        obi_rdata_i,
  input  logic                      obi_err_i,
  input  logic [`RCHK_W-1:0]        obi_rchk_i,
  // Integrity control and error reporting
  input  logic                      integrity_en_i,
  output logic                      gntpar_err_o,
  output logic                      rvalidpar_err_o,
  output logic                      rchk_err_o
);

  localparam int CNT_W = $clog2(`DATA_MAX_OUTSTANDING + 1);

  // Index 0 stays zero so the counter can pick the oldest entry directly
  obi_pkg::trk_entry_t [`DATA_MAX_OUTSTANDING:0] fifo_q;
  obi_pkg::trk_entry_t                            fifo_in;
  obi_pkg::trk_entry_t                            fifo_out;

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             accept;
  logic             gntpar_err;
  logic             gntpar_err_q;
  logic             rvalidpar_err;
  logic [1:0]       rchk_en;
  logic             rchk_err;

  ////////////////////////////////////////////////////////////
  // A channel
  ////////////////////////////////////////////////////////////

  // Core holds its request stable until granted, so it maps straight onto OBI
  assign obi_req_o     = trans_valid_i;
  assign obi_reqpar_o  = ~trans_valid_i;
  assign trans_ready_o = obi_gnt_i;
  assign obi_addr_o    = trans_addr_i;
  assign obi_we_o      = (trans_op_i == obi_pkg::OP_STORE);
  assign obi_be_o      = trans_be_i;
  assign obi_wdata_o   = trans_wdata_i;

  // Address phase checksum, wdata bytes on top and address bytes at the bottom
  assign obi_achk_o = {
    ^trans_wdata_i[31:24],
    ^trans_wdata_i[23:16],
    ^trans_wdata_i[15:8],
    ^trans_wdata_i[7:0],
    ^`OBI_DATA_ATOP,
    ~^`OBI_DATA_DBG,
    ~^{trans_be_i, obi_we_o},
    ~^{`OBI_DATA_PROT, `OBI_DATA_MEMTYPE},
    ^trans_addr_i[31:24],
    ^trans_addr_i[23:16],
    ^trans_addr_i[15:8],
    ^trans_addr_i[7:0]
  };

  assign accept = obi_req_o && obi_gnt_i;

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  // Up on accepted address phase, down on each response
  always_comb begin
    case ({accept, obi_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Grant parity
  ////////////////////////////////////////////////////////////

  // gntpar must be the inverse of gnt, checked every cycle
  assign gntpar_err = (obi_gnt_i == obi_gntpar_i);

  // Sticky over waited cycles of one address phase
  // Cleared by the grant that ends the phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gntpar_err_q <= 1'b0;
    end else if (obi_req_o) begin
      if (obi_gnt_i) begin
        gntpar_err_q <= 1'b0;
      end else begin
        gntpar_err_q <= gntpar_err_q || gntpar_err;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Tracking FIFO
  ////////////////////////////////////////////////////////////

  assign fifo_in.integrity = trans_integrity_i;
  assign fifo_in.gnterr    = gntpar_err || gntpar_err_q;
  assign fifo_in.store     = obi_we_o;

  // Newest entry enters at index 1, older ones shift up
  // A pop only moves the counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_q <= '0;
    end else if (accept) begin
      for (int i = `DATA_MAX_OUTSTANDING; i > 1; i--) begin
        fifo_q[i] <= fifo_q[i-1];
      end
      fifo_q[1] <= fifo_in;
    end
  end

  // Oldest outstanding transfer
  assign fifo_out = fifo_q[cnt_q];

  ////////////////////////////////////////////////////////////
  // R channel
  ////////////////////////////////////////////////////////////

  // rvalidpar must be the inverse of rvalid
  assign rvalidpar_err = (obi_rvalid_i == obi_rvalidpar_i);

  // Data bits only checked on loads, err bit on every response
  assign rchk_en[0] = obi_rvalid_i && integrity_en_i && !fifo_out.store;
  assign rchk_en[1] = obi_rvalid_i && integrity_en_i;

  rchk_check i_rchk_check (
    .rdata_i  (obi_rdata_i),
    .err_i    (obi_err_i),
    .rchk_i   (obi_rchk_i),
    .enable_i (rchk_en),
    .err_o    (rchk_err)
  );

  // Zero latency response path
  assign resp_valid_o      = obi_rvalid_i;
  assign resp_rdata_o      = obi_rdata_i;
  assign resp_err_o        = obi_err_i;
  assign resp_integrity_o  = fifo_out.integrity;
  assign resp_parity_err_o = rvalidpar_err || fifo_out.gnterr;
  assign resp_rchk_err_o   = rchk_err;

  // Raw error sources for the alert unit
  assign gntpar_err_o    = gntpar_err;
  assign rvalidpar_err_o = rvalidpar_err;
  assign rchk_err_o      = rchk_err;

endmodule

// ==== hdl/integrity_alert.sv ====
// Alert stays raised until cleared; only the first error cycle's top source is kept
module integrity_alert (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      gntpar_err_i,
  input  logic                      rvalidpar_err_i,
  input  logic                      rchk_err_i,
  input  logic                      alert_clr_i,
  output logic                      integrity_err_o,
  output logic                      alert_major_o,
  output integrity_pkg::alert_src_e alert_src_o
);

  integrity_pkg::alert_state_e state_q;
  integrity_pkg::alert_state_e state_d;
  integrity_pkg::alert_src_e   src_q;
  integrity_pkg::alert_src_e   src_d;
  integrity_pkg::alert_src_e   err_src;

  // Combined error, same cycle
  assign integrity_err_o = gntpar_err_i || rvalidpar_err_i || rchk_err_i;

  // Priority grant parity, rvalid parity, rchk
  always_comb begin
    if (gntpar_err_i) begin
      err_src = integrity_pkg::ALERT_GNTPAR;
    end else if (rvalidpar_err_i) begin
      err_src = integrity_pkg::ALERT_RVALIDPAR;
    end else if (rchk_err_i) begin
      err_src = integrity_pkg::ALERT_RCHK;
    end else begin
      err_src = integrity_pkg::ALERT_NONE;
    end
  end

  ////////////////////////////////////////////////////////////
  // Alert FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    src_d   = src_q;
    if (alert_clr_i) begin
      // A new error beats the clear and is captured afresh
      state_d = integrity_err_o ? integrity_pkg::ALERT_RAISED : integrity_pkg::ALERT_IDLE;
      src_d   = err_src;
    end else if (state_q == integrity_pkg::ALERT_IDLE && integrity_err_o) begin
      state_d = integrity_pkg::ALERT_RAISED;
      src_d   = err_src;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= integrity_pkg::ALERT_IDLE;
      src_q   <= integrity_pkg::ALERT_NONE;
    end else begin
      state_q <= state_d;
      src_q   <= src_d;
    end
  end

  assign alert_major_o = (state_q == integrity_pkg::ALERT_RAISED);
  assign alert_src_o   = src_q;

endmodule

// ==== hdl/data_obi_top.sv ====
// Responses have no back-pressure; the OBI side must not exceed the FIFO depth in flight
`include "data_obi_defs.svh"

module data_obi_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // Core request channel
  input  logic                      trans_valid_i,
  output logic                      trans_ready_o,
  input  obi_pkg::data_op_e         trans_op_i,
  input  logic [`DATA_ADDR_W-1:0]   trans_addr_i,
  input  logic [`DATA_W/8-1:0]      trans_be_i,
  input  logic [`DATA_W-1:0]        trans_wdata_i,
  input  logic                      trans_integrity_i,
  // Core response channel
  output logic                      resp_valid_o,
  output logic [`DATA_W-1:0]        resp_rdata_o,
  output logic                      resp_err_o,
  output logic                      resp_integrity_o,
  output logic                      resp_parity_err_o,
  output logic                      resp_rchk_err_o,
  // OBI A channel
  output logic                      obi_req_o,
  output logic                      obi_reqpar_o,
  input  logic                      obi_gnt_i,
  input  logic                      obi_gntpar_i,
  output logic [`DATA_ADDR_W-1:0]   obi_addr_o,
  output logic                      obi_we_o,
  output logic [`DATA_W/8-1:0]      obi_be_o,
  output logic [`DATA_W-1:0]        obi_wdata_o,
  output logic [`ACHK_W-1:0]        obi_achk_o,
  // OBI R channel
  input  logic                      obi_rvalid_i,
  input  logic                      obi_rvalidpar_i,
  input  logic [`DATA_W-1:0]        obi_rdata_i,
  input  logic                      obi_err_i,
  input  logic [`RCHK_W-1:0]        obi_rchk_i,
  // Integrity control and alert
  input  logic                      integrity_en_i,
  input  logic                      alert_clr_i,
  output logic                      integrity_err_o,
  output logic                      alert_major_o,
  output integrity_pkg::alert_src_e alert_src_o
);

  // Error sources from adapter to alert unit
  logic gntpar_err;
  logic rvalidpar_err;
  logic rchk_err;

  ////////////////////////////////////////////////////////////
  // Bus adapter
  ////////////////////////////////////////////////////////////

  data_obi_adapter i_adapter (
    .clk               (clk),
    .rst_n             (rst_n),
    .trans_valid_i     (trans_valid_i),
    .trans_ready_o     (trans_ready_o),
    .trans_op_i        (trans_op_i),
    .trans_addr_i      (trans_addr_i),
    .trans_be_i        (trans_be_i),
    .trans_wdata_i     (trans_wdata_i),
    .trans_integrity_i (trans_integrity_i),
    .resp_valid_o      (resp_valid_o),
    .resp_rdata_o      (resp_rdata_o),
    .resp_err_o        (resp_err_o),
    .resp_integrity_o  (resp_integrity_o),
    .resp_parity_err_o (resp_parity_err_o),
    .resp_rchk_err_o   (resp_rchk_err_o),
    .obi_req_o         (obi_req_o),
    .obi_reqpar_o      (obi_reqpar_o),
    .obi_gnt_i         (obi_gnt_i),
    .obi_gntpar_i      (obi_gntpar_i),
    .obi_addr_o        (obi_addr_o),
    .obi_we_o          (obi_we_o),
    .obi_be_o          (obi_be_o),
    .obi_wdata_o       (obi_wdata_o),
    .obi_achk_o        (obi_achk_o),
    .obi_rvalid_i      (obi_rvalid_i),
    .obi_rvalidpar_i   (obi_rvalidpar_i),
    .obi_rdata_i       (obi_rdata_i),
    .obi_err_i         (obi_err_i),
    .obi_rchk_i        (obi_rchk_i),
    .integrity_en_i    (integrity_en_i),
    .gntpar_err_o      (gntpar_err),
    .rvalidpar_err_o   (rvalidpar_err),
    .rchk_err_o        (rchk_err)
  );

  ////////////////////////////////////////////////////////////
  // Major alert
  ////////////////////////////////////////////////////////////

  integrity_alert i_alert (
    .clk             (clk),
    .rst_n           (rst_n),
    .gntpar_err_i    (gntpar_err),
    .rvalidpar_err_i (rvalidpar_err),
    .rchk_err_i      (rchk_err),
    .alert_clr_i     (alert_clr_i),
    .integrity_err_o (integrity_err_o),
    .alert_major_o   (alert_major_o),
    .alert_src_o     (alert_src_o)
  );

endmodule

// ==== dv/data_obi_asserts.sv ====
// Bound into every adapter instance; relies on the bus keeping in-flight transfers within depth
`include "data_obi_defs.svh"

module data_obi_asserts (
  input logic                                         clk,
  input logic                                         rst_n,
  input logic                                         obi_req_o,
  input logic                                         obi_gnt_i,
  input logic [`DATA_ADDR_W-1:0]                      obi_addr_o,
  input logic                                         obi_we_o,
  input logic                                         obi_rvalid_i,
  input logic [$clog2(`DATA_MAX_OUTSTANDING+1)-1:0]   cnt_q
);

  ////////////////////////////////////////////////////////////
  // A channel
  ////////////////////////////////////////////////////////////

  // Waiting request keeps address and direction
  a_hold : assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_addr_o) && $stable(obi_we_o))
    else $error("request changed or dropped before grant");

  ////////////////////////////////////////////////////////////
  // Outstanding tracking
  ////////////////////////////////////////////////////////////

  a_depth : assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= `DATA_MAX_OUTSTANDING)
    else $error("outstanding counter above FIFO depth");

  a_resp : assert property (@(posedge clk) disable iff (!rst_n)
    obi_rvalid_i |-> cnt_q != 0)
    else $error("response with nothing outstanding");

endmodule

bind data_obi_adapter data_obi_asserts i_asserts (
  .clk           (clk),
  .rst_n         (rst_n),
  .obi_req_o     (obi_req_o),
  .obi_gnt_i     (obi_gnt_i),
  .obi_addr_o    (obi_addr_o),
  .obi_we_o      (obi_we_o),
  .obi_rvalid_i  (obi_rvalid_i),
  .cnt_q         (cnt_q)
);

// ==== dv/data_obi_checker.sv ====
// Samples DUT ports on the rising edge; inputs must be driven on the falling edge
`include "data_obi_defs.svh"

module data_obi_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      trans_valid_i,
  input  logic                      trans_ready_o,
  input  obi_pkg::data_op_e         trans_op_i,
  input  logic [`DATA_ADDR_W-1:0]   trans_addr_i,
  input  logic [`DATA_W/8-1:0]      trans_be_i,
  input  logic [`DATA_W-1:0]        trans_wdata_i,
  input  logic                      trans_integrity_i,
  input  logic                      resp_valid_o,
  input  logic [`DATA_W-1:0]        resp_rdata_o,
  input  logic                      resp_err_o,
  input  logic                      resp_integrity_o,
  input  logic                      resp_parity_err_o,
  input  logic                      resp_rchk_err_o,
  input  logic                      obi_req_o,
  input  logic                      obi_reqpar_o,
  input  logic                      obi_gnt_i,
  input  logic                      obi_gntpar_i,
  input  logic [`DATA_ADDR_W-1:0]   obi_addr_o,
  input  logic                      obi_we_o,
  input  logic [`DATA_W/8-1:0]      obi_be_o,
  input  logic [`DATA_W-1:0]        obi_wdata_o,
  input  logic [`ACHK_W-1:0]        obi_achk_o,
  input  logic                      obi_rvalid_i,
  input  logic                      obi_rvalidpar_i,
  input  logic [`DATA_W-1:0]        obi_rdata_i,
  input  logic                      obi_err_i,
  input  logic [`RCHK_W-1:0]        obi_rchk_i,
  input  logic                      integrity_en_i,
  input  logic                      alert_clr_i,
  input  logic                      integrity_err_o,
  input  logic                      alert_major_o,
  input  integrity_pkg::alert_src_e alert_src_o,
  input  logic                      test_end_i,
  input  logic                      report_i,
  output int                        error_cnt_o
);

  // Per transfer {integrity, grant error, store}
  logic [2:0]                trk_q[$];
  logic                      pend_gerr;
  logic                      major_m;
  integrity_pkg::alert_src_e src_m;

  int checks;
  int errors;
  int test_checks;
  int test_errors;
  int test_no;

  assign error_cnt_o = errors;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
      test_errors++;
    end
  endtask

  // achk, wdata byte parities on top, address byte parities at the bottom
  function automatic logic [11:0] expected_achk();
    logic [11:0] a;
    a[11] = ^trans_wdata_i[31:24];
    a[10] = ^trans_wdata_i[23:16];
    a[9]  = ^trans_wdata_i[15:8];
    a[8]  = ^trans_wdata_i[7:0];
    a[7]  = ^`OBI_DATA_ATOP;
    a[6]  = ~^`OBI_DATA_DBG;
    a[5]  = ~^{trans_be_i, trans_op_i == obi_pkg::OP_STORE};
    a[4]  = ~^{`OBI_DATA_PROT, `OBI_DATA_MEMTYPE};
    a[3]  = ^trans_addr_i[31:24];
    a[2]  = ^trans_addr_i[23:16];
    a[1]  = ^trans_addr_i[15:8];
    a[0]  = ^trans_addr_i[7:0];
    return a;
  endfunction

  task automatic check_cycle();
    logic                      gerr;
    logic                      rerr;
    logic                      cerr;
    logic [2:0]                front;
    logic [4:0]                rchk_exp;
    integrity_pkg::alert_src_e prio;
    gerr = (obi_gnt_i == obi_gntpar_i);
    rerr = (obi_rvalid_i == obi_rvalidpar_i);
    cerr = 1'b0;
    compare_value("obi_req_o", 32'(obi_req_o), 32'(trans_valid_i));
    compare_value("obi_reqpar_o", 32'(obi_reqpar_o), 32'(!trans_valid_i));
    compare_value("trans_ready_o", 32'(trans_ready_o), 32'(obi_gnt_i));
    // Address phase on acceptance
    if (trans_valid_i && obi_gnt_i) begin
      compare_value("obi_addr_o", obi_addr_o, trans_addr_i);
      compare_value("obi_we_o", 32'(obi_we_o), 32'(trans_op_i == obi_pkg::OP_STORE));
      compare_value("obi_be_o", 32'(obi_be_o), 32'(trans_be_i));
      compare_value("obi_wdata_o", obi_wdata_o, trans_wdata_i);
      compare_value("obi_achk_o", 32'(obi_achk_o), 32'(expected_achk()));
    end
    compare_value("resp_valid_o", 32'(resp_valid_o), 32'(obi_rvalid_i));
    if (obi_rvalid_i) begin
      if (trk_q.size() == 0) begin
        $display("Response arrived with no transfer outstanding at %0t", $time);
        errors++;
        test_errors++;
        front = 3'b000;
      end else begin
        front = trk_q.pop_front();
      end
      rchk_exp = {^obi_err_i, ^obi_rdata_i[31:24], ^obi_rdata_i[23:16],
                  ^obi_rdata_i[15:8], ^obi_rdata_i[7:0]};
      // Data bits count for loads only
      cerr = integrity_en_i && ((!front[0] && (obi_rchk_i[3:0] != rchk_exp[3:0])) ||
                                (obi_rchk_i[4] != rchk_exp[4]));
      compare_value("resp_rdata_o", resp_rdata_o, obi_rdata_i);
      compare_value("resp_err_o", 32'(resp_err_o), 32'(obi_err_i));
      compare_value("resp_integrity_o", 32'(resp_integrity_o), 32'(front[2]));
      compare_value("resp_parity_err_o", 32'(resp_parity_err_o), 32'(rerr || front[1]));
      compare_value("resp_rchk_err_o", 32'(resp_rchk_err_o), 32'(cerr));
    end
    // Grant errors accumulate over the waiting cycles of one request
    if (trans_valid_i) begin
      if (obi_gnt_i) begin
        trk_q.push_back({trans_integrity_i, pend_gerr || gerr,
                         trans_op_i == obi_pkg::OP_STORE});
        pend_gerr = 1'b0;
      end else begin
        pend_gerr = pend_gerr || gerr;
      end
    end
    // Alert model
    if (gerr) begin
      prio = integrity_pkg::ALERT_GNTPAR;
    end else if (rerr) begin
      prio = integrity_pkg::ALERT_RVALIDPAR;
    end else if (cerr) begin
      prio = integrity_pkg::ALERT_RCHK;
    end else begin
      prio = integrity_pkg::ALERT_NONE;
    end
    compare_value("integrity_err_o", 32'(integrity_err_o), 32'(gerr || rerr || cerr));
    compare_value("alert_major_o", 32'(alert_major_o), 32'(major_m));
    compare_value("alert_src_o", 32'(alert_src_o), 32'(src_m));
    if (alert_clr_i) begin
      major_m = gerr || rerr || cerr;
      src_m   = prio;
    end else if (!major_m && (gerr || rerr || cerr)) begin
      major_m = 1'b1;
      src_m   = prio;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      trk_q.delete();
      pend_gerr = 1'b0;
      major_m   = 1'b0;
      src_m     = integrity_pkg::ALERT_NONE;
    end else begin
      check_cycle();
      if (test_end_i) begin
        test_no++;
        if (trk_q.size() != 0) begin
          $display("Test %0d ended with %0d transfers still outstanding", test_no, trk_q.size());
          errors++;
          test_errors++;
        end
        $display("Test %0d done: %0d checks, %0d errors", test_no, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
      end
      if (report_i) begin
        $display("Summary: %0d tests, %0d checks, %0d errors", test_no, checks, errors);
      end
    end
  end

endmodule

// ==== dv/data_obi_tb.sv ====
// Memory model keeps at most two transfers in flight; faults are injected only in fault tests
`include "data_obi_defs.svh"

module data_obi_tb;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      trans_valid_i;
  logic                      trans_ready_o;
  obi_pkg::data_op_e         trans_op_i;
  logic [`DATA_ADDR_W-1:0]   trans_addr_i;
  logic [`DATA_W/8-1:0]      trans_be_i;
  logic [`DATA_W-1:0]        trans_wdata_i;
  logic                      trans_integrity_i;
  logic                      resp_valid_o;
  logic [`DATA_W-1:0]        resp_rdata_o;
  logic                      resp_err_o;
  logic                      resp_integrity_o;
  logic                      resp_parity_err_o;
  logic                      resp_rchk_err_o;
  logic                      obi_req_o;
  logic                      obi_reqpar_o;
  logic                      obi_gnt_i;
  logic                      obi_gntpar_i;
  logic [`DATA_ADDR_W-1:0]   obi_addr_o;
  logic                      obi_we_o;
  logic [`DATA_W/8-1:0]      obi_be_o;
  logic [`DATA_W-1:0]        obi_wdata_o;
  logic [`ACHK_W-1:0]        obi_achk_o;
  logic                      obi_rvalid_i;
  logic                      obi_rvalidpar_i;
  logic [`DATA_W-1:0]        obi_rdata_i;
  logic                      obi_err_i;
  logic [`RCHK_W-1:0]        obi_rchk_i;
  logic                      integrity_en_i;
  logic                      alert_clr_i;
  logic                      integrity_err_o;
  logic                      alert_major_o;
  integrity_pkg::alert_src_e alert_src_o;

  // Checker handshake
  logic test_end;
  logic report;
  int   error_cnt;

  // Set once a test runs out of cycles, later tests are skipped
  logic timed_out;

  // Memory model state
  logic [31:0] lfsr = 32'h3ebdd5bd;
  logic        fault_en;
  int          resp_at_q[$];
  int          issued;
  int          completed;
  int          n_target;
  int          cycle_no;

  always #10 clk = ~clk;

  data_obi_top i_dut (.*);

  data_obi_checker i_checker (
    .*,
    .test_end_i  (test_end),
    .report_i    (report),
    .error_cnt_o (error_cnt)
  );

  ////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic rand_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  // Roughly one in eight when faults are enabled
  function automatic logic fault_hit();
    logic [31:0] v;
    v = rand_bits(3);
    return fault_en && (v[2:0] == 3'd0);
  endfunction

  ////////////////////////////////////////////////////////////
  // Core and memory stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_idle();
    trans_valid_i   = 1'b0;
    obi_gnt_i       = 1'b0;
    obi_gntpar_i    = 1'b1;
    obi_rvalid_i    = 1'b0;
    obi_rvalidpar_i = 1'b1;
    obi_rdata_i     = '0;
    obi_err_i       = 1'b0;
    obi_rchk_i      = '0;
    alert_clr_i     = 1'b0;
  endtask

  // Called on each falling edge, first retires the cycle that just ended
  task automatic step_bus();
    logic [31:0] r;
    logic [4:0]  chk;
    logic [2:0]  idx;
    if (trans_valid_i && obi_gnt_i) begin
      r = rand_bits(2);
      resp_at_q.push_back(cycle_no + int'(r[1:0]));
      trans_valid_i = 1'b0;
      issued++;
    end
    if (obi_rvalid_i) begin
      void'(resp_at_q.pop_front());
      completed++;
    end
    // Core raises a new request only after the previous one was granted
    if (!trans_valid_i && issued < n_target && rand_bit()) begin
      trans_valid_i     = 1'b1;
      trans_op_i        = rand_bit() ? obi_pkg::OP_STORE : obi_pkg::OP_LOAD;
      trans_addr_i      = rand_bits(32);
      r                 = rand_bits(4);
      trans_be_i        = r[3:0];
      trans_wdata_i     = rand_bits(32);
      trans_integrity_i = rand_bit();
    end
    // Grant only while fewer than two transfers are in flight
    obi_gnt_i    = trans_valid_i && (resp_at_q.size() < 2) && rand_bit();
    obi_gntpar_i = !obi_gnt_i;
    if (trans_valid_i && fault_hit()) begin
      obi_gntpar_i = obi_gnt_i;
    end
    // In-order response once its delay has run out
    obi_rvalid_i = (resp_at_q.size() > 0) && (resp_at_q[0] <= cycle_no);
    obi_rdata_i  = rand_bits(32);
    r            = rand_bits(3);
    obi_err_i    = obi_rvalid_i && (r[2:0] == 3'd0);
    chk = {obi_err_i, ^obi_rdata_i[31:24], ^obi_rdata_i[23:16],
           ^obi_rdata_i[15:8], ^obi_rdata_i[7:0]};
    if (obi_rvalid_i && fault_hit()) begin
      r   = rand_bits(3);
      idx = (r[2:0] > 3'd4) ? 3'd4 : r[2:0];
      chk[idx] = ~chk[idx];
    end
    obi_rchk_i      = chk;
    obi_rvalidpar_i = !obi_rvalid_i;
    if (obi_rvalid_i && fault_hit()) begin
      obi_rvalidpar_i = obi_rvalid_i;
    end
    r           = rand_bits(4);
    alert_clr_i = (r[3:0] == 4'd0);
    cycle_no++;
  endtask

  // Runs n transfers and waits for all responses
  task automatic run_test(input int n, input logic faults, input logic integ_en);
    int cycles;
    if (timed_out) begin
      return;
    end
    cycles         = 0;
    issued         = 0;
    completed      = 0;
    n_target       = n;
    fault_en       = faults;
    integrity_en_i = integ_en;
    while (completed < n && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (cycles > 30 * n) begin
        $display("Timeout: only %0d of %0d responses came back", completed, n);
        timed_out = 1'b1;
      end else begin
        step_bus();
      end
    end
    @(negedge clk);
    drive_idle();
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    rst_n             = 1'b0;
    test_end          = 1'b0;
    report            = 1'b0;
    timed_out         = 1'b0;
    fault_en          = 1'b0;
    cycle_no          = 0;
    integrity_en_i    = 1'b1;
    trans_op_i        = obi_pkg::OP_LOAD;
    trans_addr_i      = '0;
    trans_be_i        = '0;
    trans_wdata_i     = '0;
    trans_integrity_i = 1'b0;
    drive_idle();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Clean traffic, then faults with and without integrity checking
    run_test(40, 1'b0, 1'b1);
    run_test(80, 1'b1, 1'b1);
    run_test(60, 1'b1, 1'b0);

    report = 1'b1;
    @(negedge clk);
    report = 1'b0;
    if (error_cnt == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/obi_pkg.sv
hdl/integrity_pkg.sv
hdl/rchk_check.sv
hdl/data_obi_adapter.sv
hdl/integrity_alert.sv
hdl/data_obi_top.sv
dv/data_obi_asserts.sv
dv/data_obi_checker.sv
dv/data_obi_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; exit status reflects the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module data_obi_tb -o data_obi_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/data_obi_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
  exit 0
fi
exit 1
